// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FLIST     ?= mem_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/mem_stage_pkg.sv
`include "mem_stage_settings.svh"

package mem_stage_pkg;

    typedef logic [`MEM_DATA_W-1:0] word_t;
    typedef logic [`MEM_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LB       = 4'd1,
        LBU      = 4'd2,
        LH       = 4'd3,
        LHU      = 4'd4,
        LW       = 4'd5,
        SB       = 4'd6,
        SH       = 4'd7,
        SW       = 4'd8
    } mem_op_e;

    // Flags raised by fetch, decode and execute
    typedef struct packed {
        logic fetch_adel;
        logic reserved_inst;
        logic syscall;
        logic brk;
        logic overflow;
        logic eret;
    } upstream_exc_t;

    // Numeric values follow the CP0 cause codes
    typedef enum logic [4:0] {
        EXC_NONE       = 5'h00,
        EXC_ADEL       = 5'h04,
        EXC_ADES       = 5'h05,
        EXC_SYSCALL    = 5'h08,
        EXC_BREAK      = 5'h09,
        EXC_RI         = 5'h0a,
        EXC_OVERFLOW   = 5'h0c,
        EXC_ERET       = 5'h0e,
        EXC_FETCH_ADEL = 5'h0f
    } exc_code_e;

endpackage

// File: common/mem_stage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Datapath widths
`define MEM_DATA_W 32
`define MEM_REG_ADDR_W 5

// Bus size codes, log2 of the byte count
`define MEM_SIZE_BYTE 2'd0
`define MEM_SIZE_HALF 2'd1
`define MEM_SIZE_WORD 2'd2

`endif

// File: data_bus/data_bus_ctrl.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module data_bus_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  mem_stage_pkg::mem_op_e   op_i,
    input  logic                     mem_en_i,
    input  logic                     is_store_i,
    input  logic [1:0]               size_i,
    input  mem_stage_pkg::word_t     addr_i,
    input  mem_stage_pkg::word_t     wdata_i,
    input  mem_stage_pkg::reg_addr_t wd_i,
    input  logic                     wreg_i,
    input  mem_stage_pkg::word_t     alu_result_i,
    input  logic                     exc_hit_i,
    input  mem_stage_pkg::word_t     load_data_i,
    input  logic                     data_addr_ok_i,
    input  logic                     data_data_ok_i,
    output logic                     data_req_o,
    output logic                     data_wr_o,
    output logic [1:0]               data_size_o,
    output mem_stage_pkg::word_t     data_addr_o,
    output mem_stage_pkg::word_t     data_wdata_o,
    output mem_stage_pkg::mem_op_e   saved_op_o,
    output logic [1:0]               saved_addr_lo_o,
    output logic                     mem_stall_o,
    output logic                     wreg_o,
    output mem_stage_pkg::reg_addr_t wd_o,
    output mem_stage_pkg::word_t     wdata_o
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ADDR,
        WAIT_DATA
    } state_e;

    state_e    state;
    logic      issue;
    logic      idle;
    mem_op_e   saved_op;
    word_t     saved_addr;
    word_t     saved_wdata;
    logic [1:0] saved_size;
    reg_addr_t saved_wd;
    logic      saved_wr;

    assign idle  = (state == IDLE);
    assign issue = idle && mem_en_i && !exc_hit_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (issue) begin
                        state <= data_addr_ok_i ? WAIT_DATA : WAIT_ADDR;
                    end
                end
                WAIT_ADDR: begin
                    if (data_addr_ok_i) begin
                        state <= WAIT_DATA;
                    end
                end
                default: begin
                    if (data_data_ok_i) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Request fields captured once, upstream may move on after the access
    always_ff @(posedge clk) begin
        if (issue) begin
            saved_op    <= op_i;
            saved_addr  <= addr_i;
            saved_wdata <= wdata_i;
            saved_size  <= size_i;
            saved_wd    <= wd_i;
            saved_wr    <= is_store_i;
        end
    end

    assign data_req_o   = idle ? issue : (state == WAIT_ADDR);
    assign data_wr_o    = data_req_o && (idle ? is_store_i : saved_wr);
    assign data_size_o  = idle ? size_i : saved_size;
    assign data_addr_o  = idle ? addr_i : saved_addr;
    assign data_wdata_o = idle ? wdata_i : saved_wdata;

    assign saved_op_o      = saved_op;
    assign saved_addr_lo_o = saved_addr[1:0];

    // Stall drops in the data_ok cycle so the load retires there
    assign mem_stall_o = data_req_o || (!idle && !data_data_ok_i);

    always_comb begin
        if (idle) begin
            wreg_o  = wreg_i && !issue && !exc_hit_i;
            wd_o    = wd_i;
            wdata_o = alu_result_i;
        end else begin
            wreg_o  = (state == WAIT_DATA) && data_data_ok_i && !saved_wr;
            wd_o    = saved_wd;
            wdata_o = load_data_i;
        end
    end

endmodule

// File: data_bus/load_extract.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module load_extract (
    input  mem_stage_pkg::mem_op_e op_i,
    input  logic [1:0]             addr_lo_i,
    input  mem_stage_pkg::word_t   rdata_i,
    output mem_stage_pkg::word_t   load_data_o
);
    import mem_stage_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Little-endian lanes
    always_comb begin
        case (addr_lo_i)
            2'd0:    byte_sel = rdata_i[7:0];
            2'd1:    byte_sel = rdata_i[15:8];
            2'd2:    byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
    end

    assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (op_i)
            LB:      load_data_o = {{(`MEM_DATA_W-8){byte_sel[7]}}, byte_sel};
            LBU:     load_data_o = {{(`MEM_DATA_W-8){1'b0}}, byte_sel};
            LH:      load_data_o = {{(`MEM_DATA_W-16){half_sel[15]}}, half_sel};
            LHU:     load_data_o = {{(`MEM_DATA_W-16){1'b0}}, half_sel};
            default: load_data_o = rdata_i;
        endcase
    end

endmodule

// File: hw/access_decode.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module access_decode (
    input  mem_stage_pkg::mem_op_e op_i,
    input  mem_stage_pkg::word_t   addr_i,
    input  mem_stage_pkg::word_t   store_data_i,
    output logic                   mem_en_o,
    output logic                   is_store_o,
    output logic [1:0]             size_o,
    output mem_stage_pkg::word_t   wdata_o,
    output logic                   misaligned_o
);
    import mem_stage_pkg::*;

    always_comb begin
        mem_en_o     = 1'b1;
        is_store_o   = 1'b0;
        size_o       = `MEM_SIZE_BYTE;
        wdata_o      = store_data_i;
        misaligned_o = 1'b0;
        case (op_i)
            LB, LBU: begin
                size_o = `MEM_SIZE_BYTE;
            end
            LH, LHU: begin
                size_o       = `MEM_SIZE_HALF;
                misaligned_o = addr_i[0];
            end
            LW: begin
                size_o       = `MEM_SIZE_WORD;
                misaligned_o = |addr_i[1:0];
            end
            SB: begin
                is_store_o = 1'b1;
                size_o     = `MEM_SIZE_BYTE;
                // Same byte on every lane, slave picks by address
                wdata_o    = {4{store_data_i[7:0]}};
            end
            SH: begin
                is_store_o   = 1'b1;
                size_o       = `MEM_SIZE_HALF;
                wdata_o      = {2{store_data_i[15:0]}};
                misaligned_o = addr_i[0];
            end
            SW: begin
                is_store_o   = 1'b1;
                size_o       = `MEM_SIZE_WORD;
                misaligned_o = |addr_i[1:0];
            end
            default: begin
                mem_en_o = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/except_select.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module except_select (
    input  logic                         valid_i,
    input  mem_stage_pkg::upstream_exc_t exc_i,
    input  logic                         misaligned_i,
    input  logic                         is_store_i,
    output mem_stage_pkg::exc_code_e     exc_code_o
);
    import mem_stage_pkg::*;

    // Fixed priority, earliest pipeline stage first
    always_comb begin
        if (!valid_i) begin
            exc_code_o = EXC_NONE;
        end else if (exc_i.fetch_adel) begin
            exc_code_o = EXC_FETCH_ADEL;
        end else if (exc_i.reserved_inst) begin
            exc_code_o = EXC_RI;
        end else if (exc_i.syscall) begin
            exc_code_o = EXC_SYSCALL;
        end else if (exc_i.brk) begin
            exc_code_o = EXC_BREAK;
        end else if (exc_i.overflow) begin
            exc_code_o = EXC_OVERFLOW;
        end else if (misaligned_i) begin
            exc_code_o = is_store_i ? EXC_ADES : EXC_ADEL;
        end else if (exc_i.eret) begin
            exc_code_o = EXC_ERET;
        end else begin
            exc_code_o = EXC_NONE;
        end
    end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid_i,
    input  mem_stage_pkg::mem_op_e       op_i,
    input  mem_stage_pkg::word_t         addr_i,
    input  mem_stage_pkg::word_t         store_data_i,
    input  mem_stage_pkg::reg_addr_t     wd_i,
    input  logic                         wreg_i,
    input  mem_stage_pkg::word_t         alu_result_i,
    input  mem_stage_pkg::upstream_exc_t exc_i,
    output logic                         data_req_o,
    output logic                         data_wr_o,
    output logic [1:0]                   data_size_o,
    output mem_stage_pkg::word_t         data_addr_o,
    output mem_stage_pkg::word_t         data_wdata_o,
    input  mem_stage_pkg::word_t         data_rdata_i,
    input  logic                         data_addr_ok_i,
    input  logic                         data_data_ok_i,
    output logic                         mem_stall_o,
    output logic                         wreg_o,
    output mem_stage_pkg::reg_addr_t     wd_o,
    output mem_stage_pkg::word_t         wdata_o,
    output mem_stage_pkg::exc_code_e     exc_code_o
);
    import mem_stage_pkg::*;

    logic       mem_en;
    logic       is_store;
    logic [1:0] size;
    word_t      bus_wdata;
    logic       misaligned;
    logic       exc_hit;
    word_t      load_data;
    mem_op_e    saved_op;
    logic [1:0] saved_addr_lo;

    access_decode u_access_decode (
        .op_i         (op_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .mem_en_o     (mem_en),
        .is_store_o   (is_store),
        .size_o       (size),
        .wdata_o      (bus_wdata),
        .misaligned_o (misaligned)
    );

    except_select u_except_select (
        .valid_i      (valid_i),
        .exc_i        (exc_i),
        .misaligned_i (misaligned),
        .is_store_i   (is_store),
        .exc_code_o   (exc_code_o)
    );

    assign exc_hit = (exc_code_o != EXC_NONE);

    data_bus_ctrl u_data_bus_ctrl (
        .clk             (clk),
        .rst             (rst),
        .op_i            (op_i),
        .mem_en_i        (mem_en),
        .is_store_i      (is_store),
        .size_i          (size),
        .addr_i          (addr_i),
        .wdata_i         (bus_wdata),
        .wd_i            (wd_i),
        .wreg_i          (wreg_i),
        .alu_result_i    (alu_result_i),
        .exc_hit_i       (exc_hit),
        .load_data_i     (load_data),
        .data_addr_ok_i  (data_addr_ok_i),
        .data_data_ok_i  (data_data_ok_i),
        .data_req_o      (data_req_o),
        .data_wr_o       (data_wr_o),
        .data_size_o     (data_size_o),
        .data_addr_o     (data_addr_o),
        .data_wdata_o    (data_wdata_o),
        .saved_op_o      (saved_op),
        .saved_addr_lo_o (saved_addr_lo),
        .mem_stall_o     (mem_stall_o),
        .wreg_o          (wreg_o),
        .wd_o            (wd_o),
        .wdata_o         (wdata_o)
    );

    load_extract u_load_extract (
        .op_i        (saved_op),
        .addr_lo_i   (saved_addr_lo),
        .rdata_i     (data_rdata_i),
        .load_data_o (load_data)
    );

endmodule

// File: mem_stage.f
+incdir+common
common/mem_stage_pkg.sv
hw/access_decode.sv
hw/except_select.sv
data_bus/data_bus_ctrl.sv
data_bus/load_extract.sv
hw/mem_stage.sv
tests/mem_stage_checker.sv
tests/mem_stage_tb.sv

// File: tests/mem_stage_checker.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module mem_stage_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid_i,
    input  mem_stage_pkg::mem_op_e       op_i,
    input  mem_stage_pkg::word_t         addr_i,
    input  mem_stage_pkg::word_t         store_data_i,
    input  mem_stage_pkg::reg_addr_t     wd_i,
    input  logic                         wreg_i,
    input  mem_stage_pkg::word_t         alu_result_i,
    input  mem_stage_pkg::upstream_exc_t exc_i,
    input  logic                         dut_data_req_i,
    input  logic                         dut_data_wr_i,
    input  logic [1:0]                   dut_data_size_i,
    input  mem_stage_pkg::word_t         dut_data_addr_i,
    input  mem_stage_pkg::word_t         dut_data_wdata_i,
    input  mem_stage_pkg::word_t         data_rdata_i,
    input  logic                         data_addr_ok_i,
    input  logic                         data_data_ok_i,
    input  logic                         dut_mem_stall_i,
    input  logic                         dut_wreg_i,
    input  mem_stage_pkg::reg_addr_t     dut_wd_i,
    input  mem_stage_pkg::word_t         dut_wdata_i,
    input  mem_stage_pkg::exc_code_e     dut_exc_code_i,
    output int                           value_errs_o,
    output int                           proto_errs_o
);
    import mem_stage_pkg::*;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     data;
        exc_code_e exc;
    } expect_t;

    word_t   mem_copy [64];
    int      value_errs = 0;
    int      proto_errs = 0;
    int      data_oks = 0;
    logic    req_seen = 1'b0;
    logic    accepted = 1'b0;
    logic    issued;
    expect_t exp_res;

    assign value_errs_o = value_errs;
    assign proto_errs_o = proto_errs;

    // Matches the slave's power-up contents
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem_copy[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h3c5a_96e1;
        end
    end

    function automatic expect_t reference(
        input logic          valid,
        input upstream_exc_t exc,
        input mem_op_e       op,
        input word_t         addr,
        input logic          wreg,
        input reg_addr_t     wd,
        input word_t         alu,
        input word_t         mem_word
    );
        expect_t     r;
        logic        store;
        logic        bad_align;
        logic [7:0]  b;
        logic [15:0] h;
        store = (op == SB) || (op == SH) || (op == SW);
        bad_align = ((op == LH || op == LHU || op == SH) && addr[0]) ||
                    ((op == LW || op == SW) && addr[1:0] != 2'b00);
        r.exc = !valid            ? EXC_NONE :
                exc.fetch_adel    ? EXC_FETCH_ADEL :
                exc.reserved_inst ? EXC_RI :
                exc.syscall       ? EXC_SYSCALL :
                exc.brk           ? EXC_BREAK :
                exc.overflow      ? EXC_OVERFLOW :
                bad_align         ? (store ? EXC_ADES : EXC_ADEL) :
                exc.eret          ? EXC_ERET : EXC_NONE;
        r.wreg = (r.exc == EXC_NONE) && ((op == MEM_NONE) ? wreg : !store);
        r.wd = wd;
        b = mem_word[{addr[1:0], 3'b000} +: 8];
        h = mem_word[{addr[1], 4'b0000} +: 16];
        case (op)
            LB:      r.data = {{24{b[7]}}, b};
            LBU:     r.data = {24'h0, b};
            LH:      r.data = {{16{h[15]}}, h};
            LHU:     r.data = {16'h0, h};
            LW:      r.data = mem_word;
            default: r.data = alu;
        endcase
        return r;
    endfunction

    // Bus size code, log2 of the byte count
    function automatic logic [1:0] size_code(input mem_op_e op);
        case (op)
            LB, LBU, SB: return `MEM_SIZE_BYTE;
            LH, LHU, SH: return `MEM_SIZE_HALF;
            default:     return `MEM_SIZE_WORD;
        endcase
    endfunction

    // Store data as it appears on the byte lanes
    function automatic word_t lane_data(input mem_op_e op, input word_t sdata);
        case (op)
            SB:      return {4{sdata[7:0]}};
            SH:      return {2{sdata[15:0]}};
            default: return sdata;
        endcase
    endfunction

    task automatic apply_store(input mem_op_e op, input word_t addr, input word_t sdata);
        case (op)
            SB:      mem_copy[addr[7:2]][{addr[1:0], 3'b000} +: 8] = sdata[7:0];
            SH:      mem_copy[addr[7:2]][{addr[1], 4'b0000} +: 16] = sdata[15:0];
            SW:      mem_copy[addr[7:2]] = sdata;
            default: ;
        endcase
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", op_i.name(), what, expected, actual);
            value_errs++;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            req_seen = 1'b0;
            accepted = 1'b0;
            data_oks = 0;
            if (dut_data_req_i || dut_data_wr_i || dut_wreg_i || dut_mem_stall_i ||
                dut_exc_code_i != EXC_NONE) begin
                $display("Outputs not idle during reset at %0t", $time);
                proto_errs++;
            end
        end else begin
            req_seen = req_seen || dut_data_req_i;
            if (data_data_ok_i) begin
                data_oks++;
            end
            if (accepted && dut_data_req_i) begin
                $display("Request still high after the accept at %0t", $time);
                proto_errs++;
            end
            accepted = dut_data_req_i && data_addr_ok_i;
            if (dut_data_req_i && (dut_data_wr_i != (op_i inside {SB, SH, SW}) ||
                                   dut_data_addr_i != addr_i)) begin
                $display("Bus request does not match the held %s at %0t", op_i.name(), $time);
                proto_errs++;
            end
            if (dut_data_req_i) begin
                check_value("bus size", 32'(size_code(op_i)), 32'(dut_data_size_i));
                if (op_i inside {SB, SH, SW}) begin
                    check_value("bus store data", lane_data(op_i, store_data_i),
                                dut_data_wdata_i);
                end
            end
            if (data_data_ok_i && (op_i inside {LB, LBU, LH, LHU, LW}) &&
                data_rdata_i !== mem_copy[addr_i[7:2]]) begin
                $display("Returned word at %h differs from the memory copy", addr_i);
                proto_errs++;
            end
            if (dut_mem_stall_i && dut_wreg_i) begin
                $display("Write-back during a stall for %s at %0t", op_i.name(), $time);
                proto_errs++;
            end
            // The op ends in the first cycle without stall
            if (!dut_mem_stall_i) begin
                exp_res = reference(valid_i, exc_i, op_i, addr_i, wreg_i, wd_i, alu_result_i,
                                    mem_copy[addr_i[7:2]]);
                issued = (exp_res.exc == EXC_NONE) && (op_i != MEM_NONE);
                if (req_seen != issued || data_oks != (issued ? 1 : 0)) begin
                    $display("Handshake wrong for %s: request seen %0d, data_ok count %0d",
                             op_i.name(), req_seen, data_oks);
                    proto_errs++;
                end
                check_value("exception code", 32'(exp_res.exc), 32'(dut_exc_code_i));
                check_value("wreg", 32'(exp_res.wreg), 32'(dut_wreg_i));
                if (exp_res.wreg) begin
                    check_value("wd", 32'(exp_res.wd), 32'(dut_wd_i));
                    check_value("wdata", exp_res.data, dut_wdata_i);
                end
                if (issued) begin
                    apply_store(op_i, addr_i, store_data_i);
                end
                req_seen = 1'b0;
                data_oks = 0;
            end
        end
    end

endmodule

// File: tests/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_settings.svh"

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int PASS_OPS = 8;
    localparam int STORE_ROUNDS = 40;
    localparam int ALIGN_OPS = 16;
    localparam int PRIORITY_OPS = 60;
    // Each round is one store and thirteen loads
    localparam int N_OPS = PASS_OPS + STORE_ROUNDS * 14 + ALIGN_OPS + PRIORITY_OPS;
    localparam int CYCLE_LIMIT = RESET_CYCLES + 20 * N_OPS;

    logic          clk = 1'b0;
    logic          rst;
    logic          valid_i;
    mem_op_e       op_i;
    word_t         addr_i;
    word_t         store_data_i;
    reg_addr_t     wd_i;
    logic          wreg_i;
    word_t         alu_result_i;
    upstream_exc_t exc_i;
    logic          data_req_o;
    logic          data_wr_o;
    logic [1:0]    data_size_o;
    word_t         data_addr_o;
    word_t         data_wdata_o;
    word_t         data_rdata_i;
    logic          data_addr_ok_i;
    logic          data_data_ok_i;
    logic          mem_stall_o;
    logic          wreg_o;
    reg_addr_t     wd_o;
    word_t         wdata_o;
    exc_code_e     exc_code_o;

    int          value_errs;
    int          proto_errs;
    int          cycles = 0;
    int          ops = 0;
    logic [31:0] stim_rng = 32'hf284;
    // Second stream so slave delays do not track the stimulus
    logic [31:0] slave_rng = 32'hf284 ^ 32'h5bd1_e995;
    word_t       shadow [64];

    always #2 clk = ~clk;

    mem_stage DUT (.*);

    mem_stage_checker u_checker (
        .clk               (clk),
        .rst               (rst),
        .valid_i           (valid_i),
        .op_i              (op_i),
        .addr_i            (addr_i),
        .store_data_i      (store_data_i),
        .wd_i              (wd_i),
        .wreg_i            (wreg_i),
        .alu_result_i      (alu_result_i),
        .exc_i             (exc_i),
        .dut_data_req_i    (data_req_o),
        .dut_data_wr_i     (data_wr_o),
        .dut_data_size_i   (data_size_o),
        .dut_data_addr_i   (data_addr_o),
        .dut_data_wdata_i  (data_wdata_o),
        .data_rdata_i      (data_rdata_i),
        .data_addr_ok_i    (data_addr_ok_i),
        .data_data_ok_i    (data_data_ok_i),
        .dut_mem_stall_i   (mem_stall_o),
        .dut_wreg_i        (wreg_o),
        .dut_wd_i          (wd_o),
        .dut_wdata_i       (wdata_o),
        .dut_exc_code_i    (exc_code_o),
        .value_errs_o      (value_errs),
        .proto_errs_o      (proto_errs)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Same pattern as the checker's memory copy
    function automatic word_t fill_word(input int i);
        return (32'(i) * 32'h9e37_79b9) ^ 32'h3c5a_96e1;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        stim_rng = xorshift(stim_rng);
        r = stim_rng;
    endtask

    // Present one op and hold it until the stall drops
    task automatic run_op(input mem_op_e op, input word_t addr, input logic valid,
                          input upstream_exc_t exc);
        logic [31:0] r;
        @(posedge clk);
        #1;
        next_rand(r);
        op_i = op;
        addr_i = addr;
        valid_i = valid;
        exc_i = exc;
        store_data_i = r;
        wd_i = r[4:0];
        wreg_i = r[5];
        alu_result_i = {r[15:0], r[31:16]};
        ops++;
        @(negedge clk);
        while (mem_stall_o) begin
            @(negedge clk);
        end
    endtask

    // Bus slave samples at the falling edge and drives after the next rising edge
    initial begin : bus_slave
        logic       busy;
        int         wait_cnt;
        word_t      acc_addr;
        word_t      acc_wdata;
        logic [1:0] acc_size;
        logic       acc_wr;
        logic [5:0] idx;
        logic [1:0] lane;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = fill_word(i);
        end
        busy = 1'b0;
        wait_cnt = 0;
        data_addr_ok_i = 1'b1;
        data_data_ok_i = 1'b0;
        data_rdata_i = '0;
        forever begin
            @(negedge clk);
            slave_rng = xorshift(slave_rng);
            if (!busy && data_req_o && data_addr_ok_i) begin
                busy = 1'b1;
                acc_addr = data_addr_o;
                acc_wdata = data_wdata_o;
                acc_size = data_size_o;
                acc_wr = data_wr_o;
                wait_cnt = int'(slave_rng % 3);
            end else if (busy && data_data_ok_i) begin
                idx = acc_addr[7:2];
                lane = acc_addr[1:0];
                if (acc_wr) begin
                    case (acc_size)
                        `MEM_SIZE_BYTE: shadow[idx][{lane, 3'b000} +: 8] =
                            acc_wdata[{lane, 3'b000} +: 8];
                        `MEM_SIZE_HALF: shadow[idx][{lane[1], 4'b0000} +: 16] =
                            acc_wdata[{lane[1], 4'b0000} +: 16];
                        default: shadow[idx] = acc_wdata;
                    endcase
                end
                busy = 1'b0;
                wait_cnt = int'(slave_rng % 3);
            end else if (busy || data_req_o) begin
                wait_cnt--;
            end
            @(posedge clk);
            #1;
            data_addr_ok_i = !busy && (wait_cnt == 0);
            data_data_ok_i = busy && (wait_cnt == 0);
            data_rdata_i = (busy && wait_cnt == 0) ? shadow[acc_addr[7:2]] : slave_rng;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, errors: value %0d, protocol %0d",
                     cycles, value_errs, proto_errs);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin : stimulus
        upstream_exc_t none;
        upstream_exc_t exc;
        mem_op_e       op;
        mem_op_e       align_ops [5];
        logic [31:0]   r;
        logic [31:0]   x;
        logic [1:0]    lo;
        word_t         base;
        none = '0;
        align_ops = '{LH, LHU, SH, LW, SW};
        rst = 1'b1;
        valid_i = 1'b0;
        op_i = MEM_NONE;
        addr_i = '0;
        store_data_i = '0;
        wd_i = '0;
        wreg_i = 1'b0;
        alu_result_i = '0;
        exc_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (PASS_OPS) begin
            next_rand(x);
            run_op(MEM_NONE, x, 1'b1, none);
        end

        repeat (STORE_ROUNDS) begin
            next_rand(r);
            next_rand(x);
            op = (r[1:0] == 2'd0) ? SB : ((r[1:0] == 2'd1) ? SH : SW);
            if (op == SH) begin
                x[0] = 1'b0;
            end else if (op == SW) begin
                x[1:0] = 2'b00;
            end
            run_op(op, x, 1'b1, none);
            base = {x[31:2], 2'b00};
            for (int k = 0; k < 4; k++) begin
                run_op(LB, base + 32'(k), 1'b1, none);
                run_op(LBU, base + 32'(k), 1'b1, none);
            end
            for (int k = 0; k < 4; k += 2) begin
                run_op(LH, base + 32'(k), 1'b1, none);
                run_op(LHU, base + 32'(k), 1'b1, none);
            end
            run_op(LW, base, 1'b1, none);
        end

        repeat (ALIGN_OPS) begin
            next_rand(r);
            next_rand(x);
            op = align_ops[int'(r % 5)];
            lo = x[1:0];
            if (op == LW || op == SW) begin
                if (lo == 2'b00) begin
                    lo = 2'b10;
                end
            end else begin
                lo[0] = 1'b1;
            end
            run_op(op, {x[31:2], lo}, 1'b1, none);
        end

        // Sparse flags, any op, valid low a quarter of the time
        repeat (PRIORITY_OPS) begin
            next_rand(r);
            next_rand(x);
            exc = r[5:0] & r[11:6];
            op = mem_op_e'(r[15:12] % 4'd9);
            run_op(op, x, r[16] | r[17], exc);
        end

        repeat (2) @(posedge clk);
        $display("Errors: value %0d, protocol %0d, over %0d ops", value_errs, proto_errs, ops);
        if (value_errs + proto_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
